// File: ceres_macros.svh
`ifndef CERES_MACROS_SVH
`define CERES_MACROS_SVH

// data path width of the core.
`define XLEN 32

// machine-mode csr addresses, as in the privileged spec.
`define CSR_MSTATUS  12'h300
`define CSR_MTVEC    12'h305
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC     12'h341
`define CSR_MCAUSE   12'h342
`define CSR_MTVAL    12'h343

// mstatus fields kept by this core.
`define MSTATUS_MIE  3
`define MSTATUS_MPIE 7

`endif

// File: ceres_param.sv
`include "ceres_macros.svh"

package ceres_param;

  typedef logic [`XLEN-1:0] word_t;  // operands, pc values and csr data.
  typedef logic [11:0] csr_addr_t;   // csr index.
  typedef logic [1:0] fwd_sel_t;     // bit 1 ex/mem result, bit 0 wb data.

  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND,
    LUI_B,  // passes operand b.
    MUL,
    CSRRW,
    CSRRS,
    CSRRC
  } alu_op_e;

  typedef enum logic [3:0] {
    NO_BJ,
    BEQ,
    BNE,
    BLT,
    BGE,
    BLTU,
    BGEU,
    JAL,
    JALR
  } pc_sel_e;

  typedef enum logic [2:0] {
    i_alu,
    u_jal,
    i_jalr,
    b_br,
    csr_op,
    mret
  } instr_type_e;

  typedef enum logic [1:0] {
    NO_STALL,
    LSU_STALL,
    ALU_STALL
  } stall_e;

  typedef enum logic {
    NO_EXCEPTION,
    INSTR_MISALIGNED
  } exc_type_e;

  // shift-add multiplier sequencing.
  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    DONE
  } mul_state_e;

endpackage

// File: alu.sv
`timescale 1ns/1ps
`include "ceres_macros.svh"

module alu (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  ceres_param::word_t   alu_a_i,
  input  ceres_param::word_t   alu_b_i,
  input  ceres_param::word_t   csr_rdata_i,
  input  ceres_param::alu_op_e op_sel_i,
  output ceres_param::word_t   alu_o,
  output logic                 zero_o,
  output logic                 slt_o,
  output logic                 sltu_o,
  output logic                 alu_stall_o
);
  import ceres_param::*;

  localparam int LOG_XLEN = $clog2(`XLEN);

  logic [LOG_XLEN-1:0] shamt;
  logic                mul_req;
  mul_state_e          mul_state;
  logic [LOG_XLEN-1:0] mul_cnt;    // iterations already done.
  word_t               mul_acc;    // partial product.
  word_t               mul_mcand;  // multiplicand, shifted left each step.
  word_t               mul_mplier; // multiplier, shifted right each step.

  assign shamt   = alu_b_i[LOG_XLEN-1:0];
  assign mul_req = (op_sel_i == MUL);

  assign zero_o = (alu_a_i == alu_b_i);
  assign slt_o  = ($signed(alu_a_i) < $signed(alu_b_i));
  assign sltu_o = (alu_a_i < alu_b_i);

  always_comb begin
    unique case (op_sel_i)
      ADD:     alu_o = alu_a_i + alu_b_i;
      SUB:     alu_o = alu_a_i - alu_b_i;
      SLL:     alu_o = alu_a_i << shamt;
      SLT:     alu_o = word_t'(slt_o);
      SLTU:    alu_o = word_t'(sltu_o);
      XOR:     alu_o = alu_a_i ^ alu_b_i;
      SRL:     alu_o = alu_a_i >> shamt;
      SRA:     alu_o = word_t'($signed(alu_a_i) >>> shamt);
      OR:      alu_o = alu_a_i | alu_b_i;
      AND:     alu_o = alu_a_i & alu_b_i;
      LUI_B:   alu_o = alu_b_i;
      MUL:     alu_o = mul_acc;                  // valid once DONE is reached.
      CSRRW:   alu_o = alu_b_i;
      CSRRS:   alu_o = csr_rdata_i | alu_b_i;
      CSRRC:   alu_o = csr_rdata_i & ~alu_b_i;
      default: alu_o = '0;
    endcase
  end

  // stall covers the start cycle plus the BUSY cycles, XLEN in total.
  assign alu_stall_o = (mul_state == BUSY) || ((mul_state == IDLE) && mul_req);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mul_state <= IDLE;
      mul_cnt   <= '0;
    end else begin
      unique case (mul_state)
        IDLE: begin
          if (mul_req) begin
            mul_state <= BUSY;
            mul_cnt   <= LOG_XLEN'(1);  // first step runs in the start cycle.
          end
        end
        BUSY: begin
          mul_cnt <= mul_cnt + 1'b1;
          if (mul_cnt == LOG_XLEN'(`XLEN - 1)) begin
            mul_state <= DONE;
          end
        end
        DONE: begin
          mul_state <= IDLE;  // a held MUL restarts from here.
        end
        default: begin
          mul_state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((mul_state == IDLE) && mul_req) begin
      mul_acc    <= alu_b_i[0] ? alu_a_i : '0;
      mul_mcand  <= alu_a_i << 1;
      mul_mplier <= alu_b_i >> 1;
    end else if (mul_state == BUSY) begin
      if (mul_mplier[0]) begin
        mul_acc <= mul_acc + mul_mcand;
      end
      mul_mcand  <= mul_mcand << 1;
      mul_mplier <= mul_mplier >> 1;
    end
  end

  // a multiply never holds the pipeline longer than its iteration count.
  stall_bound_a : assert property (
    @(posedge clk_i) disable iff (rst_i)
    alu_stall_o [* `XLEN] |=> !alu_stall_o
  ) else $error("alu stall held past XLEN cycles.");

endmodule

// File: cs_reg_file.sv
`timescale 1ns/1ps
`include "ceres_macros.svh"

module cs_reg_file (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  ceres_param::stall_e      stall_i,
  input  logic                     rd_en_i,
  input  logic                     wr_en_i,
  input  ceres_param::csr_addr_t   csr_idx_i,
  input  ceres_param::word_t       csr_wdata_i,
  input  logic                     trap_active_i,
  input  logic                     de_trap_active_i,
  input  ceres_param::word_t       trap_cause_i,
  input  ceres_param::word_t       trap_mepc_i,
  input  ceres_param::word_t       trap_tval_i,
  input  ceres_param::instr_type_e instr_type_i,
  output ceres_param::word_t       csr_rdata_o,
  output ceres_param::word_t       mtvec_o,
  output ceres_param::word_t       mepc_o
);
  import ceres_param::*;

  word_t mstatus;
  word_t mtvec;
  word_t mscratch;
  word_t mepc;
  word_t mcause;
  word_t mtval;

  word_t wdata_masked;
  logic  commit_en;
  logic  trap_take;
  logic  mret_take;
  logic  csr_write;

  // drops the bits that this core does not implement.
  function automatic word_t csr_wmask(csr_addr_t idx, word_t data);
    word_t masked;
    masked = data;
    case (idx)
      `CSR_MSTATUS: begin
        masked                = '0;
        masked[`MSTATUS_MIE]  = data[`MSTATUS_MIE];
        masked[`MSTATUS_MPIE] = data[`MSTATUS_MPIE];
      end
      `CSR_MTVEC, `CSR_MEPC: begin
        masked[1:0] = 2'b00;  // direct mode, word aligned.
      end
      default: begin
        masked = data;
      end
    endcase
    return masked;
  endfunction

  assign commit_en    = (stall_i == NO_STALL);
  assign trap_take    = commit_en && trap_active_i;
  assign mret_take    = commit_en && de_trap_active_i && (instr_type_i == mret);
  assign csr_write    = commit_en && wr_en_i && !trap_active_i && !de_trap_active_i;
  assign wdata_masked = csr_wmask(csr_idx_i, csr_wdata_i);

  // reads see the value before this cycle's update.
  always_comb begin
    csr_rdata_o = '0;
    if (rd_en_i) begin
      case (csr_idx_i)
        `CSR_MSTATUS:  csr_rdata_o = mstatus;
        `CSR_MTVEC:    csr_rdata_o = mtvec;
        `CSR_MSCRATCH: csr_rdata_o = mscratch;
        `CSR_MEPC:     csr_rdata_o = mepc;
        `CSR_MCAUSE:   csr_rdata_o = mcause;
        `CSR_MTVAL:    csr_rdata_o = mtval;
        default:       csr_rdata_o = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mstatus  <= '0;
      mtvec    <= '0;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mtval    <= '0;
    end else if (trap_take) begin
      mepc                   <= {trap_mepc_i[`XLEN-1:2], 2'b00};
      mcause                 <= trap_cause_i;
      mtval                  <= trap_tval_i;
      mstatus[`MSTATUS_MPIE] <= mstatus[`MSTATUS_MIE];  // stack the enable.
      mstatus[`MSTATUS_MIE]  <= 1'b0;
    end else if (mret_take) begin
      mstatus[`MSTATUS_MIE]  <= mstatus[`MSTATUS_MPIE];
      mstatus[`MSTATUS_MPIE] <= 1'b1;
    end else if (csr_write) begin
      case (csr_idx_i)
        `CSR_MSTATUS:  mstatus  <= wdata_masked;
        `CSR_MTVEC:    mtvec    <= wdata_masked;
        `CSR_MSCRATCH: mscratch <= wdata_masked;
        `CSR_MEPC:     mepc     <= wdata_masked;
        `CSR_MCAUSE:   mcause   <= wdata_masked;
        `CSR_MTVAL:    mtval    <= wdata_masked;
        default: ;  // unknown index, write dropped.
      endcase
    end
  end

  assign mtvec_o = mtvec;
  assign mepc_o  = mepc;

  // decode never raises trap entry and trap return in the same cycle.
  trap_excl_a : assert property (
    @(posedge clk_i) disable iff (rst_i)
    !(trap_active_i && de_trap_active_i)
  ) else $error("trap entry and mret active together.");

endmodule

// File: execution.sv
`timescale 1ns/1ps
`include "ceres_macros.svh"

module execution (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  ceres_param::stall_e      stall_i,
  input  ceres_param::fwd_sel_t    fwd_a_i,
  input  ceres_param::fwd_sel_t    fwd_b_i,
  input  ceres_param::word_t       alu_result_i,
  input  ceres_param::word_t       wb_data_i,
  input  ceres_param::word_t       r1_data_i,
  input  ceres_param::word_t       r2_data_i,
  input  logic [1:0]               alu_in1_sel_i,
  input  logic                     alu_in2_sel_i,
  input  logic                     rd_csr_i,
  input  logic                     wr_csr_i,
  input  ceres_param::csr_addr_t   csr_idx_i,
  input  logic                     csr_or_data_i,
  input  logic                     trap_active_i,
  input  logic                     de_trap_active_i,
  input  ceres_param::word_t       trap_cause_i,
  input  ceres_param::word_t       trap_tval_i,
  input  ceres_param::word_t       trap_mepc_i,
  input  ceres_param::word_t       pc_i,
  input  ceres_param::word_t       pc_incr_i,
  input  ceres_param::word_t       imm_i,
  input  ceres_param::pc_sel_e     pc_sel_i,
  input  ceres_param::alu_op_e     alu_ctrl_i,
  input  ceres_param::instr_type_e instr_type_i,
  output ceres_param::word_t       write_data_o,
  output ceres_param::word_t       pc_target_o,
  output ceres_param::word_t       alu_result_o,
  output logic                     pc_sel_o,
  output logic                     alu_stall_o,
  output ceres_param::exc_type_e   exc_type_o,
  output ceres_param::word_t       mtvec_o
);
  import ceres_param::*;

  word_t data_a;
  word_t operand_a;
  word_t operand_b;
  word_t alu_result;
  word_t csr_rdata;
  word_t mepc;
  logic  ex_zero;
  logic  ex_slt;
  logic  ex_sltu;
  logic  br_taken;

  // ex/mem result wins over writeback data.
  function automatic word_t fwd_mux(fwd_sel_t sel, word_t rf_val);
    word_t val;
    val = rf_val;
    if (sel[1]) begin
      val = alu_result_i;
    end else if (sel[0]) begin
      val = wb_data_i;
    end
    return val;
  endfunction

  always_comb begin
    data_a       = fwd_mux(fwd_a_i, r1_data_i);
    write_data_o = fwd_mux(fwd_b_i, r2_data_i);  // store data and rs2 operand.

    case (alu_in1_sel_i)
      2'b01:   operand_a = pc_incr_i;
      2'b10:   operand_a = pc_i;
      default: operand_a = data_a;
    endcase
    operand_b = alu_in2_sel_i ? imm_i : write_data_o;
  end

  always_comb begin
    if (instr_type_i == mret) begin
      pc_target_o = mepc;
    end else if (pc_sel_i == JALR) begin
      pc_target_o = (data_a + imm_i) & ~(`XLEN'(1));
    end else begin
      pc_target_o = pc_i + imm_i;
    end

    case (pc_sel_i)
      BEQ:       br_taken = ex_zero;
      BNE:       br_taken = !ex_zero;
      BLT:       br_taken = ex_slt;
      BGE:       br_taken = !ex_slt || ex_zero;
      BLTU:      br_taken = ex_sltu;
      BGEU:      br_taken = !ex_sltu || ex_zero;
      JAL, JALR: br_taken = 1'b1;
      default:   br_taken = 1'b0;
    endcase
    pc_sel_o = br_taken || (instr_type_i == mret);

    exc_type_o = (pc_sel_o && pc_target_o[0]) ? INSTR_MISALIGNED : NO_EXCEPTION;
  end

  always_comb begin
    if (rd_csr_i && csr_or_data_i) begin
      alu_result_o = csr_rdata;  // old csr value goes to rd.
    end else if ((instr_type_i == u_jal) || (instr_type_i == i_jalr)) begin
      alu_result_o = pc_incr_i;  // link address.
    end else begin
      alu_result_o = alu_result;
    end
  end

  alu i_alu (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .alu_a_i     (operand_a),
    .alu_b_i     (operand_b),
    .csr_rdata_i (csr_rdata),
    .op_sel_i    (alu_ctrl_i),
    .alu_o       (alu_result),
    .zero_o      (ex_zero),
    .slt_o       (ex_slt),
    .sltu_o      (ex_sltu),
    .alu_stall_o (alu_stall_o)
  );

  cs_reg_file i_cs_reg_file (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .stall_i          (stall_i),
    .rd_en_i          (rd_csr_i),
    .wr_en_i          (wr_csr_i),
    .csr_idx_i        (csr_idx_i),
    .csr_wdata_i      (alu_result),
    .trap_active_i    (trap_active_i),
    .de_trap_active_i (de_trap_active_i),
    .trap_cause_i     (trap_cause_i),
    .trap_mepc_i      (trap_mepc_i),
    .trap_tval_i      (trap_tval_i),
    .instr_type_i     (instr_type_i),
    .csr_rdata_o      (csr_rdata),
    .mtvec_o          (mtvec_o),
    .mepc_o           (mepc)
  );

  // misaligned fetch only comes from a taken branch or jump, mepc stays word aligned.
  misalign_taken_a : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (exc_type_o == INSTR_MISALIGNED) |-> (pc_sel_o && (instr_type_i != mret))
  ) else $error("misaligned target flagged without a taken branch or jump.");

endmodule

// File: tb_execution.sv
`timescale 1ns/1ps
`include "ceres_macros.svh"

module tb_execution;
  import ceres_param::*;

  localparam int NUM_OPS    = 2000;
  localparam int RST_CYCLES = 10;
  localparam int MAX_CYCLES = NUM_OPS * (`XLEN + 2) + RST_CYCLES;
  localparam int SH_W       = $clog2(`XLEN);

  logic        clk;
  logic        rst;
  stall_e      stall;
  fwd_sel_t    fwd_a;
  fwd_sel_t    fwd_b;
  word_t       alu_result_in;
  word_t       wb_data;
  word_t       r1_data;
  word_t       r2_data;
  logic [1:0]  alu_in1_sel;
  logic        alu_in2_sel;
  logic        rd_csr;
  logic        wr_csr;
  csr_addr_t   csr_idx;
  logic        csr_or_data;
  logic        trap_active;
  logic        de_trap_active;
  word_t       trap_cause;
  word_t       trap_tval;
  word_t       trap_mepc;
  word_t       pc;
  word_t       pc_incr;
  word_t       imm;
  pc_sel_e     pc_sel;
  alu_op_e     alu_ctrl;
  instr_type_e instr_type;
  word_t       write_data;
  word_t       pc_target;
  word_t       alu_result;
  logic        pc_taken;
  logic        alu_stall;
  exc_type_e   exc_type;
  word_t       mtvec;

  // reference copies of the csrs.
  word_t m_mstatus;
  word_t m_mtvec;
  word_t m_mscratch;
  word_t m_mepc;
  word_t m_mcause;
  word_t m_mtval;
  int    cycles = 0;

  execution DUT (
    .clk_i            (clk),
    .rst_i            (rst),
    .stall_i          (stall),
    .fwd_a_i          (fwd_a),
    .fwd_b_i          (fwd_b),
    .alu_result_i     (alu_result_in),
    .wb_data_i        (wb_data),
    .r1_data_i        (r1_data),
    .r2_data_i        (r2_data),
    .alu_in1_sel_i    (alu_in1_sel),
    .alu_in2_sel_i    (alu_in2_sel),
    .rd_csr_i         (rd_csr),
    .wr_csr_i         (wr_csr),
    .csr_idx_i        (csr_idx),
    .csr_or_data_i    (csr_or_data),
    .trap_active_i    (trap_active),
    .de_trap_active_i (de_trap_active),
    .trap_cause_i     (trap_cause),
    .trap_tval_i      (trap_tval),
    .trap_mepc_i      (trap_mepc),
    .pc_i             (pc),
    .pc_incr_i        (pc_incr),
    .imm_i            (imm),
    .pc_sel_i         (pc_sel),
    .alu_ctrl_i       (alu_ctrl),
    .instr_type_i     (instr_type),
    .write_data_o     (write_data),
    .pc_target_o      (pc_target),
    .alu_result_o     (alu_result),
    .pc_sel_o         (pc_taken),
    .alu_stall_o      (alu_stall),
    .exc_type_o       (exc_type),
    .mtvec_o          (mtvec)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("SOME TESTS FAILED");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic check(input word_t actual, input word_t expected, input string msg);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
      $display("SOME TESTS FAILED");
      $fatal(1, "check failed");
    end
  endtask

  // bit 1 picks the ex/mem result, bit 0 the writeback data.
  function automatic word_t forward(fwd_sel_t sel, word_t rf_val);
    if (sel[1]) return alu_result_in;
    if (sel[0]) return wb_data;
    return rf_val;
  endfunction

  function automatic word_t csr_read(csr_addr_t idx);
    case (idx)
      `CSR_MSTATUS:  return m_mstatus;
      `CSR_MTVEC:    return m_mtvec;
      `CSR_MSCRATCH: return m_mscratch;
      `CSR_MEPC:     return m_mepc;
      `CSR_MCAUSE:   return m_mcause;
      `CSR_MTVAL:    return m_mtval;
      default:       return '0;
    endcase
  endfunction

  function automatic csr_addr_t pick_csr_idx();
    case ($urandom_range(0, 6))
      0:       return `CSR_MSTATUS;
      1:       return `CSR_MTVEC;
      2:       return `CSR_MSCRATCH;
      3:       return `CSR_MEPC;
      4:       return `CSR_MCAUSE;
      5:       return `CSR_MTVAL;
      default: return 12'h7c0;  // unimplemented index.
    endcase
  endfunction

  function automatic word_t alu_model(alu_op_e op, word_t a, word_t b, word_t csr_old);
    logic [SH_W-1:0] sh;
    sh = b[SH_W-1:0];
    case (op)
      ADD:     return a + b;
      SUB:     return a - b;
      SLL:     return a << sh;
      SLT:     return word_t'($signed(a) < $signed(b));
      SLTU:    return word_t'(a < b);
      XOR:     return a ^ b;
      SRL:     return a >> sh;
      SRA:     return word_t'($signed(a) >>> sh);
      OR:      return a | b;
      AND:     return a & b;
      MUL:     return a * b;
      CSRRW:   return b;
      CSRRS:   return csr_old | b;
      CSRRC:   return csr_old & ~b;
      default: return b;  // LUI_B.
    endcase
  endfunction

  task automatic model_operands(output word_t rs1, output word_t op_a, output word_t op_b);
    rs1 = forward(fwd_a, r1_data);
    case (alu_in1_sel)
      2'b01:   op_a = pc_incr;
      2'b10:   op_a = pc;
      default: op_a = rs1;
    endcase
    op_b = alu_in2_sel ? imm : forward(fwd_b, r2_data);
  endtask

  // state the DUT takes on the coming edge.
  task automatic update_csr_model(input word_t wdata);
    if (stall == NO_STALL) begin
      if (trap_active) begin
        m_mepc                   = {trap_mepc[`XLEN-1:2], 2'b00};
        m_mcause                 = trap_cause;
        m_mtval                  = trap_tval;
        m_mstatus[`MSTATUS_MPIE] = m_mstatus[`MSTATUS_MIE];
        m_mstatus[`MSTATUS_MIE]  = 1'b0;
      end else if (de_trap_active && (instr_type == mret)) begin
        m_mstatus[`MSTATUS_MIE]  = m_mstatus[`MSTATUS_MPIE];
        m_mstatus[`MSTATUS_MPIE] = 1'b1;
      end else if (wr_csr && !de_trap_active) begin
        case (csr_idx)
          `CSR_MSTATUS:  m_mstatus  = wdata & ((1 << `MSTATUS_MIE) | (1 << `MSTATUS_MPIE));
          `CSR_MTVEC:    m_mtvec    = {wdata[`XLEN-1:2], 2'b00};
          `CSR_MSCRATCH: m_mscratch = wdata;
          `CSR_MEPC:     m_mepc     = {wdata[`XLEN-1:2], 2'b00};
          `CSR_MCAUSE:   m_mcause   = wdata;
          `CSR_MTVAL:    m_mtval    = wdata;
          default: ;
        endcase
      end
    end
  endtask

  task automatic check_cycle();
    word_t rs1;
    word_t op_a;
    word_t op_b;
    word_t csr_old;
    word_t alu_val;
    word_t wb_exp;
    word_t target;
    word_t jump_sum;
    logic  taken;
    @(negedge clk);
    model_operands(rs1, op_a, op_b);
    csr_old = rd_csr ? csr_read(csr_idx) : '0;
    alu_val = alu_model(alu_ctrl, op_a, op_b, csr_old);
    if (rd_csr && csr_or_data) begin
      wb_exp = csr_old;
    end else if ((instr_type == u_jal) || (instr_type == i_jalr)) begin
      wb_exp = pc_incr;
    end else begin
      wb_exp = alu_val;
    end
    case (pc_sel)
      BEQ:       taken = (op_a == op_b);
      BNE:       taken = (op_a != op_b);
      BLT:       taken = ($signed(op_a) < $signed(op_b));
      BGE:       taken = ($signed(op_a) >= $signed(op_b));
      BLTU:      taken = (op_a < op_b);
      BGEU:      taken = (op_a >= op_b);
      JAL, JALR: taken = 1'b1;
      default:   taken = 1'b0;
    endcase
    taken    = taken || (instr_type == mret);
    jump_sum = rs1 + imm;
    if (instr_type == mret) begin
      target = m_mepc;
    end else if (pc_sel == JALR) begin
      target = {jump_sum[`XLEN-1:1], 1'b0};
    end else begin
      target = pc + imm;
    end
    check(alu_result, wb_exp, "alu_result_o");
    check(write_data, forward(fwd_b, r2_data), "write_data_o");
    check(word_t'(pc_taken), word_t'(taken), "pc_sel_o");
    check(pc_target, target, "pc_target_o");
    check(word_t'(exc_type), word_t'(taken && target[0]), "exc_type_o");
    check(mtvec, m_mtvec, "mtvec_o");
    check(word_t'(alu_stall), '0, "alu_stall_o");
    update_csr_model(alu_val);
  endtask

  // called right after a rising edge.
  task automatic drive_random_base();
    word_t pc_v;
    pc_v = word_t'($urandom) & ~word_t'(3);
    fwd_a          <= fwd_sel_t'($urandom_range(0, 3));
    fwd_b          <= fwd_sel_t'($urandom_range(0, 3));
    alu_result_in  <= word_t'($urandom);
    wb_data        <= word_t'($urandom);
    r1_data        <= word_t'($urandom);
    r2_data        <= word_t'($urandom);
    alu_in1_sel    <= 2'($urandom_range(0, 3));
    alu_in2_sel    <= 1'($urandom_range(0, 1));
    rd_csr         <= 1'b0;
    wr_csr         <= 1'b0;
    csr_idx        <= pick_csr_idx();
    csr_or_data    <= 1'($urandom_range(0, 1));
    trap_active    <= 1'b0;
    de_trap_active <= 1'b0;
    trap_cause     <= word_t'($urandom);
    trap_tval      <= word_t'($urandom);
    trap_mepc      <= word_t'($urandom);
    pc             <= pc_v;
    pc_incr        <= pc_v + 4;
    imm            <= word_t'($urandom);
    pc_sel         <= NO_BJ;
    alu_ctrl       <= alu_op_e'($urandom_range(0, 10));
    instr_type     <= i_alu;
    stall          <= ($urandom_range(0, 3) == 0) ? stall_e'($urandom_range(1, 2)) : NO_STALL;
  endtask

  task automatic drive_branch_op();
    pc_sel_e kind;
    word_t   rs_v;
    kind = pc_sel_e'($urandom_range(0, 8));
    rs_v = word_t'($urandom);
    @(posedge clk);
    drive_random_base();
    pc_sel      <= kind;
    alu_in1_sel <= 2'b00;
    alu_in2_sel <= 1'b0;
    alu_ctrl    <= SUB;
    instr_type  <= (kind == JAL) ? u_jal : ((kind == JALR) ? i_jalr : b_br);
    if ($urandom_range(0, 1)) begin
      imm <= word_t'($urandom) | 1;  // odd offset, misaligned target.
    end
    if ($urandom_range(0, 3) == 0) begin
      fwd_a   <= 2'b00;
      fwd_b   <= 2'b00;
      r1_data <= rs_v;
      r2_data <= rs_v;
    end
  endtask

  task automatic drive_csr_op();
    @(posedge clk);
    drive_random_base();
    alu_ctrl    <= alu_op_e'($urandom_range(int'(CSRRW), int'(CSRRC)));
    rd_csr      <= ($urandom_range(0, 7) != 0);
    wr_csr      <= ($urandom_range(0, 7) != 0);
    csr_or_data <= ($urandom_range(0, 3) != 0);
    instr_type  <= csr_op;
  endtask

  task automatic drive_csr_read(input csr_addr_t idx);
    @(posedge clk);
    drive_random_base();
    alu_ctrl    <= CSRRS;
    alu_in2_sel <= 1'b1;
    imm         <= '0;
    rd_csr      <= 1'b1;
    csr_or_data <= 1'b1;
    csr_idx     <= idx;
    stall       <= NO_STALL;
    instr_type  <= csr_op;
  endtask

  task automatic run_trap_sequence();
    word_t status_v;
    status_v                = '0;
    status_v[`MSTATUS_MIE]  = 1'($urandom_range(0, 1));
    status_v[`MSTATUS_MPIE] = 1'($urandom_range(0, 1));
    @(posedge clk);
    drive_random_base();
    alu_ctrl    <= CSRRW;
    alu_in2_sel <= 1'b1;
    imm         <= status_v;
    wr_csr      <= 1'b1;
    csr_idx     <= `CSR_MSTATUS;
    stall       <= NO_STALL;
    instr_type  <= csr_op;
    check_cycle();
    @(posedge clk);
    drive_random_base();
    trap_active <= 1'b1;
    wr_csr      <= 1'($urandom_range(0, 1));  // loses against the trap.
    stall       <= NO_STALL;
    check_cycle();
    drive_csr_read(`CSR_MEPC);
    check_cycle();
    drive_csr_read(`CSR_MCAUSE);
    check_cycle();
    drive_csr_read(`CSR_MTVAL);
    check_cycle();
    drive_csr_read(`CSR_MSTATUS);
    check_cycle();
    @(posedge clk);
    drive_random_base();
    de_trap_active <= 1'b1;
    instr_type     <= mret;
    stall          <= NO_STALL;
    check_cycle();
    drive_csr_read(`CSR_MSTATUS);
    check_cycle();
  endtask

  // ends on the falling edge of the first cycle with the stall low.
  task automatic count_stall(output int n);
    n = 0;
    @(negedge clk);
    while (alu_stall && (n < `XLEN + 4)) begin
      n++;
      @(negedge clk);
    end
  endtask

  task automatic run_mul();
    word_t rs1;
    word_t op_a;
    word_t op_b;
    word_t prod;
    int    n;
    @(posedge clk);
    drive_random_base();
    alu_ctrl <= MUL;
    count_stall(n);
    model_operands(rs1, op_a, op_b);
    prod = op_a * op_b;
    check(word_t'(n), word_t'(`XLEN), "mul stall length");
    check(alu_result, prod, "mul product");
    if ($urandom_range(0, 1)) begin
      count_stall(n);  // operand hold restarts the multiply.
      check(word_t'(n), word_t'(`XLEN), "back to back mul stall length");
      check(alu_result, prod, "back to back mul product");
    end
  endtask

  initial begin
    void'($urandom(32'h5d74_19e7));
    rst            = 1'b1;
    stall          = NO_STALL;
    fwd_a          = 2'b00;
    fwd_b          = 2'b00;
    alu_result_in  = '0;
    wb_data        = '0;
    r1_data        = '0;
    r2_data        = '0;
    alu_in1_sel    = 2'b00;
    alu_in2_sel    = 1'b0;
    rd_csr         = 1'b0;
    wr_csr         = 1'b0;
    csr_idx        = '0;
    csr_or_data    = 1'b0;
    trap_active    = 1'b0;
    de_trap_active = 1'b0;
    trap_cause     = '0;
    trap_tval      = '0;
    trap_mepc      = '0;
    pc             = '0;
    pc_incr        = '0;
    imm            = '0;
    pc_sel         = NO_BJ;
    alu_ctrl       = ADD;
    instr_type     = i_alu;
    m_mstatus      = '0;
    m_mtvec        = '0;
    m_mscratch     = '0;
    m_mepc         = '0;
    m_mcause       = '0;
    m_mtval        = '0;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    check_cycle();  // reset state, csrs zero and no stall.
    for (int i = 0; i < NUM_OPS; i++) begin
      case ($urandom_range(0, 9))
        3, 4: begin
          drive_branch_op();
          check_cycle();
        end
        5, 6: begin
          drive_csr_op();
          check_cycle();
        end
        7: run_trap_sequence();
        8: run_mul();
        default: begin
          @(posedge clk);
          drive_random_base();
          check_cycle();
        end
      endcase
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// File: ceres_exec.f
+incdir+.
ceres_param.sv
alu.sv
cs_reg_file.sv
execution.sv
tb_execution.sv

// File: Bender.yml
package:
  name: ceres_exec

export_include_dirs:
  - .

sources:
  - ceres_param.sv
  - alu.sv
  - cs_reg_file.sv
  - execution.sv
  - target: test
    files:
      - tb_execution.sv
